// File: classifier_stim.txt
// one input beat per line, lanes 0 to 15 from left to right
// each value is a signed 16-bit hex word, four beats make one frame
// frame 0
0012 0034 ffee 0101 0007 fff0 0200 0003 0045 ff80 0011 0000 0066 fffd 0029 0100
0021 ff43 0005 0008 0190 fe70 0030 0002 ffff 0001 0077 ff00 0004 0050 fff8 0013
0abc f543 0102 0033 0044 0055 ff66 0077 0088 ff99 00aa 00bb ffcc 00dd 00ee 00ff
0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
// frame 1, classes 1 and 3 tie at the top
0003 0000 0000 0000 0000 0000 0000 0000 0005 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// frame 2
ffff fffe fffd fffc fffb fffa fff9 fff8 fff7 fff6 fff5 fff4 fff3 fff2 fff1 fff0
ff00 fe00 fd00 fc00 fb00 fa00 f900 f800 f700 f600 f500 f400 f300 f200 f100 f000
0100 ff10 0020 ffe3 0444 fbbb 0015 ffa0 0060 0007 ff07 0321 fcde 0042 ffbe 0099
fff0 0010 ffe0 0020 ffd0 0030 ffc0 0040 ffb0 0050 ffa0 0060 ff90 0070 ff80 0080
// frame 3, every class scores the same
0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010
0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010
0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010
0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010 0010
// frame 4, extreme values
7fff 8000 7fff 8000 7fff 8000 7fff 8000 7fff 8000 7fff 8000 7fff 8000 7fff 8000
8000 8000 8000 8000 7fff 7fff 7fff 7fff 8000 8000 8000 8000 7fff 7fff 7fff 7fff
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
8000 0000 7fff 0000 8000 0000 7fff 0000 8000 0000 7fff 0000 8000 0000 7fff 0000
// frame 5
1234 edcb 0456 fba9 0789 f876 0abc f543 0def f210 0135 fecb 0246 fdba 0357 fca9
0000 0001 0000 ffff 0000 0002 0000 fffe 0000 0003 0000 fffd 0000 0004 0000 fffc
0300 0280 0200 0180 0100 0080 0000 ff80 ff00 fe80 fe00 fd80 fd00 fc80 fc00 fb80
0055 00aa ff55 ffaa 0033 00cc ff33 ffcc 0011 00ee ff11 ffee 0022 00dd ff22 ffdd

// File: tb.f
cnn_pkg.sv
flatten_buffer.sv
weight_rom.sv
dense_layer.sv
classifier_top.sv
classifier_sva.sv
tb_classifier.sv

// File: tb_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_classifier;

  localparam int data_width = 16;
  localparam int width = 2;
  localparam int num_classes = 4;
  localparam int acc_width = 40;
  localparam int lanes = cnn_pkg::lanes;
  localparam int beats_per_frame = width * width;
  localparam int features = beats_per_frame * lanes;
  localparam int frames = 6;
  localparam int total_beats = frames * beats_per_frame;
  localparam int timeout_cycles = frames * 250 + 500;  // about 80 cycles per frame is typical

  logic clk = 1'b0;
  logic rst;
  logic [data_width-1:0] data_in [lanes];
  logic in_valid;
  logic in_ready;
  logic signed [acc_width-1:0] score;
  logic [1:0] score_class;
  logic score_valid;
  logic score_last;
  logic [1:0] best_class;
  logic score_ready;

  logic signed [data_width-1:0] stim_mem [total_beats * lanes];
  logic [31:0] rng;
  logic running;
  logic hold;
  int sent_beats;
  int next_beat;
  int frames_done;
  int score_idx;
  int errors;
  int frame_errors;
  int intake_errors;
  int tests_passed;
  int tests_failed;
  int cycles;
  longint exp_score;

  always #50 clk = ~clk;

  classifier_top #(
    .data_width(data_width),
    .width(width),
    .num_classes(num_classes),
    .acc_width(acc_width)
  ) classifier_top_inst (
    .clk(clk),
    .rst(rst),
    .data_in0(data_in[0]),
    .data_in1(data_in[1]),
    .data_in2(data_in[2]),
    .data_in3(data_in[3]),
    .data_in4(data_in[4]),
    .data_in5(data_in[5]),
    .data_in6(data_in[6]),
    .data_in7(data_in[7]),
    .data_in8(data_in[8]),
    .data_in9(data_in[9]),
    .data_in10(data_in[10]),
    .data_in11(data_in[11]),
    .data_in12(data_in[12]),
    .data_in13(data_in[13]),
    .data_in14(data_in[14]),
    .data_in15(data_in[15]),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .score(score),
    .score_class(score_class),
    .score_valid(score_valid),
    .score_last(score_last),
    .best_class(best_class),
    .score_ready(score_ready)
  );

  // --------------------
  // reference model

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int expected_weight(input int cls, input int idx);
    return ((cls * 5 + idx * 3) % 16) - 8;
  endfunction

  // flat feature index is beat times lanes plus lane, same as the file layout
  function automatic longint expected_score(input int frame, input int cls);
    longint sum;
    sum = 0;
    for (int f = 0; f < features; f++) begin
      sum += longint'(stim_mem[frame * features + f]) * expected_weight(cls, f);
    end
    return sum;
  endfunction

  function automatic int expected_best(input int frame);
    longint best_val;
    int best;
    best = 0;
    best_val = expected_score(frame, 0);
    for (int c = 1; c < num_classes; c++) begin
      if (expected_score(frame, c) > best_val) begin  // lowest index keeps a tie
        best_val = expected_score(frame, c);
        best = c;
      end
    end
    return best;
  endfunction

  // --------------------
  // input driver with random gaps and output stalls

  always @(posedge clk) begin
    if (running) begin
      rng = xorshift(rng);
      next_beat = sent_beats;
      hold = in_valid && !in_ready;  // an offered beat stays until taken
      if (in_valid && in_ready) begin
        if (sent_beats / beats_per_frame > frames_done + 1) begin
          errors++;
          intake_errors++;
          $display("Fail at %0t: beat %0d accepted while two frames were pending",
                   $time, sent_beats);
        end
        next_beat = sent_beats + 1;
      end
      sent_beats <= next_beat;
      if (!hold) begin
        if (next_beat < total_beats && rng[1:0] != 2'b00) begin
          in_valid <= 1'b1;
          for (int l = 0; l < lanes; l++) begin
            data_in[l] <= stim_mem[next_beat * lanes + l];
          end
        end else begin
          in_valid <= 1'b0;
        end
      end
      score_ready <= (rng[31:16] % 3) != 0;  // low about one cycle in three
    end
  end

  // --------------------
  // score monitor

  always @(posedge clk) begin
    if (running && score_valid && score_ready) begin
      if (frames_done >= frames) begin
        errors++;
        $display("Fail at %0t: score transferred after the last frame", $time);
      end else begin
        exp_score = expected_score(frames_done, score_idx);
        if (int'(score_class) != score_idx) begin
          errors++;
          frame_errors++;
          $display("Fail at %0t: frame %0d score class %0d, expected %0d",
                   $time, frames_done, score_class, score_idx);
        end
        if (longint'(score) != exp_score) begin
          errors++;
          frame_errors++;
          $display("Fail at %0t: frame %0d class %0d score %0d, expected %0d",
                   $time, frames_done, score_idx, score, exp_score);
        end
        if (score_last != (score_idx == num_classes - 1)) begin
          errors++;
          frame_errors++;
          $display("Fail at %0t: frame %0d score_last %0b on class %0d",
                   $time, frames_done, score_last, score_idx);
        end
        if (score_last && int'(best_class) != expected_best(frames_done)) begin
          errors++;
          frame_errors++;
          $display("Fail at %0t: frame %0d best class %0d, expected %0d",
                   $time, frames_done, best_class, expected_best(frames_done));
        end
        if (score_idx == num_classes - 1) begin
          if (frame_errors == 0) begin
            tests_passed++;
            $display("frame %0d scores and best class %0d: pass", frames_done, best_class);
          end else begin
            tests_failed++;
            $display("frame %0d scores and best class: FAIL", frames_done);
          end
          frame_errors = 0;
          score_idx = 0;
          frames_done <= frames_done + 1;
        end else begin
          score_idx++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles with %0d of %0d frames scored",
               cycles, frames_done, frames);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rst <= 1'b1;
    in_valid <= 1'b0;
    score_ready <= 1'b0;
    running <= 1'b0;
    for (int l = 0; l < lanes; l++) begin
      data_in[l] <= '0;
    end
    rng = 32'h337a;
    sent_beats = 0;
    frames_done = 0;
    score_idx = 0;
    errors = 0;
    frame_errors = 0;
    intake_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles = 0;
    $readmemh("classifier_stim.txt", stim_mem);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (score_valid !== 1'b0 || in_ready !== 1'b1) begin
      errors++;
      tests_failed++;
      $display("Fail at %0t: after reset score_valid %0b in_ready %0b", $time,
               score_valid, in_ready);
    end else begin
      tests_passed++;
      $display("reset state: pass");
    end
    @(posedge clk);
    running <= 1'b1;
    wait (frames_done == frames);
    repeat (100) @(posedge clk);  // quiet period catches a duplicated frame
    if (sent_beats != total_beats) begin
      errors++;
      tests_failed++;
      $display("Fail at %0t: %0d beats accepted, expected %0d", $time, sent_beats,
               total_beats);
    end else begin
      tests_passed++;
      $display("frame count, %0d frames from %0d beats: pass", frames_done, sent_beats);
    end
    if (intake_errors == 0) begin
      tests_passed++;
      $display("input hold-off under back-pressure: pass");
    end else begin
      tests_failed++;
      $display("input hold-off under back-pressure: FAIL");
    end
    if (classifier_top_inst.classifier_sva_inst.fail_count == 0) begin
      tests_passed++;
      $display("handshake assertions: pass");
    end else begin
      errors++;
      tests_failed++;
      $display("handshake assertions failed %0d times",
               classifier_top_inst.classifier_sva_inst.fail_count);
    end
    $display("tests passed %0d, tests failed %0d, check errors %0d", tests_passed,
             tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: classifier_sva.sv
`timescale 1ns/1ps
`default_nettype none

module classifier_sva #(
  parameter int data_width = 16,
  parameter int acc_width = 40,
  parameter int num_classes = 4,
  localparam int class_width = (num_classes > 1) ? $clog2(num_classes) : 1
) (
  input wire clk,
  input wire rst,
  input wire in_ready,
  input wire [data_width-1:0] feat,
  input wire feat_valid,
  input wire feat_ready,
  input wire [acc_width-1:0] score,
  input wire [class_width-1:0] score_class,
  input wire score_valid,
  input wire score_ready,
  input wire score_last,
  input var cnn_pkg::buf_state_e buf_state,
  input var cnn_pkg::dense_state_e dense_state
);

  int fail_count = 0;

  // --------------------
  // stream stability

  a_feat_hold: assert property (@(posedge clk) disable iff (rst)
    feat_valid && !feat_ready |=> feat_valid && $stable(feat))
    else begin
      $error("feat changed while stalled");
      fail_count++;
    end

  a_score_hold: assert property (@(posedge clk) disable iff (rst)
    score_valid && !score_ready |=> score_valid && $stable(score) && $stable(score_class))
    else begin
      $error("score changed while stalled");
      fail_count++;
    end

  // --------------------
  // control

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(in_ready && feat_valid))
    else begin
      $error("buffer filling and draining at once");
      fail_count++;
    end

  a_last_class: assert property (@(posedge clk) disable iff (rst)
    score_last |-> score_class == class_width'(num_classes - 1))
    else begin
      $error("score_last on a class other than the last");
      fail_count++;
    end

  // the feature counter and the read pointer must finish the frame together
  a_emit_after_drain: assert property (@(posedge clk) disable iff (rst)
    $rose(dense_state == cnn_pkg::EMIT) |->
      $past(buf_state) == cnn_pkg::DRAIN && buf_state == cnn_pkg::FILL)
    else begin
      $error("scores started out of step with the buffer drain");
      fail_count++;
    end

endmodule

bind classifier_top classifier_sva #(
  .data_width(data_width),
  .acc_width(acc_width),
  .num_classes(num_classes)
) classifier_sva_inst (
  .clk(clk),
  .rst(rst),
  .in_ready(in_ready),
  .feat(feat),
  .feat_valid(feat_valid),
  .feat_ready(feat_ready),
  .score(score),
  .score_class(score_class),
  .score_valid(score_valid),
  .score_ready(score_ready),
  .score_last(score_last),
  .buf_state(flatten_buffer_inst.state),
  .dense_state(dense_layer_inst.state)
);

`default_nettype wire

// File: classifier_top.sv
`timescale 1ns/1ps
`default_nettype none

module classifier_top #(
  parameter int data_width = 16,
  parameter int width = 2,
  parameter int num_classes = 4,
  parameter int acc_width = 40,
  localparam int features = width * width * cnn_pkg::lanes,
  localparam int idx_width = $clog2(features),
  localparam int class_width = (num_classes > 1) ? $clog2(num_classes) : 1
) (
  input wire clk,
  input wire rst,
  input wire [data_width-1:0] data_in0,
  input wire [data_width-1:0] data_in1,
  input wire [data_width-1:0] data_in2,
  input wire [data_width-1:0] data_in3,
  input wire [data_width-1:0] data_in4,
  input wire [data_width-1:0] data_in5,
  input wire [data_width-1:0] data_in6,
  input wire [data_width-1:0] data_in7,
  input wire [data_width-1:0] data_in8,
  input wire [data_width-1:0] data_in9,
  input wire [data_width-1:0] data_in10,
  input wire [data_width-1:0] data_in11,
  input wire [data_width-1:0] data_in12,
  input wire [data_width-1:0] data_in13,
  input wire [data_width-1:0] data_in14,
  input wire [data_width-1:0] data_in15,
  input wire in_valid,
  output logic in_ready,
  output logic signed [acc_width-1:0] score,
  output logic [class_width-1:0] score_class,
  output logic score_valid,
  output logic score_last,
  output logic [class_width-1:0] best_class,
  input wire score_ready
);

  // --------------------
  // serial feature stream between the stages

  logic [data_width-1:0] feat;
  logic feat_valid;
  logic feat_ready;
  logic [idx_width-1:0] feat_index;  // lets the dense layer prefetch weights

  flatten_buffer #(
    .data_width(data_width),
    .width(width)
  ) flatten_buffer_inst (
    .clk(clk),
    .rst(rst),
    .data_in0(data_in0),
    .data_in1(data_in1),
    .data_in2(data_in2),
    .data_in3(data_in3),
    .data_in4(data_in4),
    .data_in5(data_in5),
    .data_in6(data_in6),
    .data_in7(data_in7),
    .data_in8(data_in8),
    .data_in9(data_in9),
    .data_in10(data_in10),
    .data_in11(data_in11),
    .data_in12(data_in12),
    .data_in13(data_in13),
    .data_in14(data_in14),
    .data_in15(data_in15),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .feat(feat),
    .feat_valid(feat_valid),
    .feat_index(feat_index),
    .feat_ready(feat_ready)
  );

  dense_layer #(
    .data_width(data_width),
    .width(width),
    .num_classes(num_classes),
    .acc_width(acc_width)
  ) dense_layer_inst (
    .clk(clk),
    .rst(rst),
    .feat(feat),
    .feat_valid(feat_valid),
    .feat_index(feat_index),
    .feat_ready(feat_ready),
    .score(score),
    .score_class(score_class),
    .score_valid(score_valid),
    .score_last(score_last),
    .best_class(best_class),
    .score_ready(score_ready)
  );

endmodule

`default_nettype wire

// File: dense_layer.sv
`timescale 1ns/1ps
`default_nettype none

module dense_layer #(
  parameter int data_width = 16,
  parameter int width = 2,
  parameter int num_classes = 4,
  parameter int acc_width = 40,
  localparam int features = width * width * cnn_pkg::lanes,
  localparam int idx_width = $clog2(features),
  localparam int class_width = (num_classes > 1) ? $clog2(num_classes) : 1
) (
  input wire clk,
  input wire rst,
  input wire [data_width-1:0] feat,
  input wire feat_valid,
  input wire [idx_width-1:0] feat_index,
  output logic feat_ready,
  output logic signed [acc_width-1:0] score,
  output logic [class_width-1:0] score_class,
  output logic score_valid,
  output logic score_last,
  output logic [class_width-1:0] best_class,
  input wire score_ready
);

  localparam int ww = cnn_pkg::weight_width;

  cnn_pkg::dense_state_e state;
  logic [idx_width-1:0] feat_cnt;
  logic [idx_width-1:0] next_index;
  logic [idx_width-1:0] rom_addr;
  logic [num_classes*ww-1:0] weights;
  logic signed [acc_width-1:0] acc [num_classes];
  logic signed [data_width+ww-1:0] prod [num_classes];
  logic signed [acc_width-1:0] best_score;
  logic [class_width-1:0] best_idx;
  logic feat_fire;
  logic score_fire;
  logic last_feat;
  logic take_new;

  // --------------------
  // weight fetch, one cycle ahead of the value

  assign next_index = (feat_index == idx_width'(features - 1)) ? '0 : feat_index + 1'b1;
  assign rom_addr = feat_fire ? next_index : feat_index;

  weight_rom #(
    .width(width),
    .num_classes(num_classes)
  ) weight_rom_inst (
    .clk(clk),
    .rst(rst),
    .addr(rom_addr),
    .weights(weights)
  );

  always_comb begin
    for (int c = 0; c < num_classes; c++) begin
      prod[c] = $signed(feat) * $signed(weights[c*ww +: ww]);
    end
  end

  // --------------------
  // handshakes and score output

  assign feat_ready = (state == cnn_pkg::ACCUM);
  assign feat_fire = feat_valid && feat_ready;
  assign last_feat = (feat_cnt == idx_width'(features - 1));

  assign score_valid = (state == cnn_pkg::EMIT);
  assign score_fire = score_valid && score_ready;
  assign score = acc[score_class];
  assign score_last = score_valid && (score_class == class_width'(num_classes - 1));

  // strictly greater wins, so ties keep the lower class
  assign take_new = (score_class == '0) || (score > best_score);
  assign best_class = take_new ? score_class : best_idx;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= cnn_pkg::ACCUM;
      feat_cnt <= '0;
      score_class <= '0;
      best_score <= '0;
      best_idx <= '0;
      for (int c = 0; c < num_classes; c++) begin
        acc[c] <= '0;
      end
    end else begin
      case (state)
        cnn_pkg::ACCUM: begin
          if (feat_fire) begin
            for (int c = 0; c < num_classes; c++) begin
              acc[c] <= acc[c] + acc_width'(prod[c]);
            end
            if (last_feat) begin
              feat_cnt <= '0;
              score_class <= '0;
              state <= cnn_pkg::EMIT;
            end else begin
              feat_cnt <= feat_cnt + 1'b1;
            end
          end
        end
        cnn_pkg::EMIT: begin
          if (score_fire) begin
            if (take_new) begin
              best_score <= score;
              best_idx <= score_class;
            end
            if (score_last) begin
              for (int c = 0; c < num_classes; c++) begin
                acc[c] <= '0;  // ready for the next frame
              end
              score_class <= '0;
              state <= cnn_pkg::ACCUM;
            end else begin
              score_class <= score_class + 1'b1;
            end
          end
        end
        default: state <= cnn_pkg::ACCUM;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: weight_rom.sv
`timescale 1ns/1ps
`default_nettype none

module weight_rom #(
  parameter int width = 2,
  parameter int num_classes = 4,
  localparam int features = width * width * cnn_pkg::lanes,
  localparam int idx_width = $clog2(features),
  localparam int ww = cnn_pkg::weight_width
) (
  input wire clk,
  input wire rst,
  input wire [idx_width-1:0] addr,
  output logic [num_classes*ww-1:0] weights
);

  logic [num_classes*ww-1:0] rom_rows [features];

  // one row packs the weights of every class for a single feature
  function automatic logic [num_classes*ww-1:0] row_of(input int idx);
    logic [num_classes*ww-1:0] row;
    for (int c = 0; c < num_classes; c++) begin
      row[c*ww +: ww] = cnn_pkg::weight_of(c, idx);
    end
    return row;
  endfunction

  for (genvar f = 0; f < features; f++) begin : gen_row
    assign rom_rows[f] = row_of(f);  // constant after elaboration
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      weights <= '0;
    end else begin
      weights <= rom_rows[addr];  // row lines up with the value offered next cycle
    end
  end

endmodule

`default_nettype wire

// File: flatten_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module flatten_buffer #(
  parameter int data_width = 16,
  parameter int width = 2,
  localparam int features = width * width * cnn_pkg::lanes,
  localparam int idx_width = $clog2(features)
) (
  input wire clk,
  input wire rst,
  input wire [data_width-1:0] data_in0,
  input wire [data_width-1:0] data_in1,
  input wire [data_width-1:0] data_in2,
  input wire [data_width-1:0] data_in3,
  input wire [data_width-1:0] data_in4,
  input wire [data_width-1:0] data_in5,
  input wire [data_width-1:0] data_in6,
  input wire [data_width-1:0] data_in7,
  input wire [data_width-1:0] data_in8,
  input wire [data_width-1:0] data_in9,
  input wire [data_width-1:0] data_in10,
  input wire [data_width-1:0] data_in11,
  input wire [data_width-1:0] data_in12,
  input wire [data_width-1:0] data_in13,
  input wire [data_width-1:0] data_in14,
  input wire [data_width-1:0] data_in15,
  input wire in_valid,
  output logic in_ready,
  output logic [data_width-1:0] feat,
  output logic feat_valid,
  output logic [idx_width-1:0] feat_index,
  input wire feat_ready
);

  localparam int beats = width * width;
  localparam int beat_width = (beats > 1) ? $clog2(beats) : 1;

  logic [data_width-1:0] mem [features];
  logic [data_width-1:0] lane_data [cnn_pkg::lanes];
  logic [beat_width-1:0] wr_beat;
  logic [idx_width-1:0] rd_ptr;
  cnn_pkg::buf_state_e state;
  logic in_fire;
  logic out_fire;
  logic last_beat;
  logic last_feat;

  assign lane_data[0] = data_in0;
  assign lane_data[1] = data_in1;
  assign lane_data[2] = data_in2;
  assign lane_data[3] = data_in3;
  assign lane_data[4] = data_in4;
  assign lane_data[5] = data_in5;
  assign lane_data[6] = data_in6;
  assign lane_data[7] = data_in7;
  assign lane_data[8] = data_in8;
  assign lane_data[9] = data_in9;
  assign lane_data[10] = data_in10;
  assign lane_data[11] = data_in11;
  assign lane_data[12] = data_in12;
  assign lane_data[13] = data_in13;
  assign lane_data[14] = data_in14;
  assign lane_data[15] = data_in15;

  // --------------------
  // handshakes

  assign in_ready = (state == cnn_pkg::FILL);
  assign in_fire = in_valid && in_ready;
  assign feat_valid = (state == cnn_pkg::DRAIN);
  assign out_fire = feat_valid && feat_ready;
  assign last_beat = (wr_beat == beat_width'(beats - 1));
  assign last_feat = (rd_ptr == idx_width'(features - 1));

  assign feat = mem[rd_ptr];  // value is held while the consumer stalls
  assign feat_index = rd_ptr;

  // lane-major layout, flat index is beat times lanes plus lane
  always_ff @(posedge clk) begin
    if (in_fire) begin
      for (int l = 0; l < cnn_pkg::lanes; l++) begin
        mem[int'(wr_beat) * cnn_pkg::lanes + l] <= lane_data[l];
      end
    end
  end

  // --------------------
  // fill and drain control

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= cnn_pkg::FILL;
      wr_beat <= '0;
      rd_ptr <= '0;
    end else begin
      case (state)
        cnn_pkg::FILL: begin
          if (in_fire) begin
            if (last_beat) begin
              wr_beat <= '0;
              state <= cnn_pkg::DRAIN;  // whole frame stored
            end else begin
              wr_beat <= wr_beat + 1'b1;
            end
          end
        end
        cnn_pkg::DRAIN: begin
          if (out_fire) begin
            if (last_feat) begin
              rd_ptr <= '0;  // dense layer relies on index 0 while filling
              state <= cnn_pkg::FILL;
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
            end
          end
        end
        default: state <= cnn_pkg::FILL;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cnn_pkg.sv
`default_nettype none

package cnn_pkg;

  // --------------------
  // sizes shared by the datapath

  localparam int lanes = 16;  // channel lanes in one input beat
  localparam int weight_width = 8;  // signed weight per class

  // --------------------
  // state encodings

  typedef enum logic {
    FILL,  // collecting beats of a frame
    DRAIN  // replaying the frame as a serial stream
  } buf_state_e;

  typedef enum logic {
    ACCUM,  // multiply-accumulate over all features
    EMIT  // scores go out one class per transfer
  } dense_state_e;

  // --------------------
  // fixed weight rule, evaluated at elaboration by the ROM

  function automatic logic signed [weight_width-1:0] weight_of(input int cls, input int idx);
    int raw;
    raw = (cls * 5 + idx * 3) % 16;
    return weight_width'(raw - 8);  // spread over -8 to 7
  endfunction

endpackage

`default_nettype wire
